//--- Bender.yml
package:
  name: inst_window

sources:
  - design/iw_cfg_pkg.sv
  - design/iw_types_pkg.sv
  - design/operand_capture.sv
  - design/issue_select.sv
  - design/window_compact.sv
  - design/inst_window.sv
  - target: test
    files:
      - tests/inst_window_props.sv
      - tests/tb_inst_window.sv

//--- compile.f
design/iw_cfg_pkg.sv
design/iw_types_pkg.sv
design/operand_capture.sv
design/issue_select.sv
design/window_compact.sv
design/inst_window.sv
tests/inst_window_props.sv
tests/tb_inst_window.sv

//--- design/inst_window.sv
`default_nettype none

module inst_window (
    input  wire                              clk,
    input  wire                              reset,

    // decoder side
    input  wire                              d_done,
    input  wire iw_types_pkg::dec_inst_t     d_inst,
    output logic                             accept_able,

    // writeback broadcast
    input  wire iw_types_pkg::wakeup_t       wakeup,

    // branch resolution
    input  wire                              branch_hazard,
    input  wire iw_types_pkg::context_t      hazard_context,

    // execute side
    output logic                             order,
    output iw_types_pkg::issue_inst_t        issue,
    input  wire                              accepted
);

    import iw_cfg_pkg::*;
    import iw_types_pkg::*;

    window_entry_t          entries [WINDOW_SIZE-1:0];
    window_entry_t          updated [WINDOW_SIZE-1:0];
    window_entry_t          incoming;

    logic [WINDOW_SIZE-1:0] taken_mask;
    logic [WINDOW_SIZE-1:0] keep;
    slot_id_t               source_slot [WINDOW_SIZE-1:0];
    logic [WINDOW_SIZE-1:0] source_valid;
    slot_id_t               fill_slot;
    logic                   take;

    issue_select i_issue_select (
        .entries    (entries),
        .accepted   (accepted),
        .order      (order),
        .issue      (issue),
        .taken_mask (taken_mask)
    );

    operand_capture i_operand_capture (
        .entries        (entries),
        .taken_mask     (taken_mask),
        .wakeup         (wakeup),
        .branch_hazard  (branch_hazard),
        .hazard_context (hazard_context),
        .d_done         (d_done),
        .d_inst         (d_inst),
        .updated        (updated),
        .incoming       (incoming)
    );

    always_comb begin
        for (int k = 0; k < WINDOW_SIZE; k++) begin
            keep[k] = updated[k].valid;
        end
    end

    window_compact i_window_compact (
        .keep         (keep),
        .source_slot  (source_slot),
        .source_valid (source_valid),
        .fill_slot    (fill_slot),
        .accept_able  (accept_able)
    );

    // decoder handshake
    assign take = d_done && accept_able;

    // survivors shift down, new instruction goes to the first free slot
    always_ff @(posedge clk) begin
        for (int k = 0; k < WINDOW_SIZE; k++) begin
            if (reset) begin
                entries[k].valid <= 1'b0;
            end else if (source_valid[k]) begin
                entries[k] <= updated[source_slot[k]];
            end else if (take && (fill_slot == slot_id_t'(k))) begin
                // valid already low if flushed on arrival
                entries[k] <= incoming;
            end else begin
                entries[k].valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/issue_select.sv
`default_nettype none

module issue_select (
    input  wire iw_types_pkg::window_entry_t entries [iw_cfg_pkg::WINDOW_SIZE-1:0],
    input  wire                              accepted,
    output logic                             order,
    output iw_types_pkg::issue_inst_t        issue,
    output logic [iw_cfg_pkg::WINDOW_SIZE-1:0] taken_mask
);

    import iw_cfg_pkg::*;
    import iw_types_pkg::*;

    logic [WINDOW_SIZE-1:0] all_ready;
    slot_id_t               sel;

    always_comb begin
        for (int k = 0; k < WINDOW_SIZE; k++) begin
            all_ready[k] = entries[k].valid
                         && entries[k].inst.rs1.ready
                         && entries[k].inst.rs2.ready
                         && (|entries[k].inst.exec_type);
        end
    end

    // lowest ready slot wins, slot order is age order
    always_comb begin
        order = 1'b0;
        sel   = '0;
        for (int k = 0; k < WINDOW_SIZE; k++) begin
            if (!order && all_ready[k]) begin
                order = 1'b1;
                sel   = slot_id_t'(k);
            end
        end
    end

    always_comb begin
        issue.exec_type = entries[sel].inst.exec_type;
        issue.func3     = entries[sel].inst.func3;
        issue.rs1_data  = entries[sel].inst.rs1.data;
        issue.rs2_data  = entries[sel].inst.rs2.data;
        issue.rd        = entries[sel].inst.rd;
        issue.ctx       = entries[sel].inst.ctx;
    end

    // slot leaves only on the execute handshake
    always_comb begin
        taken_mask      = '0;
        taken_mask[sel] = order && accepted;
    end

endmodule

`default_nettype wire

//--- design/iw_cfg_pkg.sv
`default_nettype none

package iw_cfg_pkg;

    // number of slots in the window
    localparam int WINDOW_SIZE = 8;

    // operand data width
    localparam int WORD_WIDTH = 32;

    // physical register tag width
    localparam int PREG_WIDTH = 6;

    // one bit per branch context
    localparam int CONTEXT_WIDTH = 4;

    localparam int SLOT_ID_WIDTH = 3;

    // exec class bits: 0 alu, 1 branch, 2 memory, 3 jump
    localparam int EXEC_TYPE_WIDTH = 4;

endpackage

`default_nettype wire

//--- design/iw_types_pkg.sv
`default_nettype none

package iw_types_pkg;

    import iw_cfg_pkg::*;

    typedef logic [WORD_WIDTH-1:0]      word_t;
    typedef logic [PREG_WIDTH-1:0]      preg_t;
    typedef logic [CONTEXT_WIDTH-1:0]   context_t;
    typedef logic [SLOT_ID_WIDTH-1:0]   slot_id_t;
    // all zero means no operation
    typedef logic [EXEC_TYPE_WIDTH-1:0] exec_type_t;
    typedef logic [2:0]                 func3_t;

    // source operand, data valid once ready is set
    typedef struct packed {
        logic  ready;
        preg_t tag;
        word_t data;
    } operand_t;

    typedef struct packed {
        exec_type_t exec_type;
        func3_t     func3;
        operand_t   rs1;
        operand_t   rs2;
        preg_t      rd;
        context_t   ctx;
    } dec_inst_t;

    typedef struct packed {
        logic      valid;
        dec_inst_t inst;
    } window_entry_t;

    // writeback result broadcast
    typedef struct packed {
        logic  valid;
        preg_t tag;
        word_t data;
    } wakeup_t;

    typedef struct packed {
        exec_type_t exec_type;
        func3_t     func3;
        word_t      rs1_data;
        word_t      rs2_data;
        preg_t      rd;
        context_t   ctx;
    } issue_inst_t;

endpackage

`default_nettype wire

//--- design/operand_capture.sv
`default_nettype none

module operand_capture (
    input  wire iw_types_pkg::window_entry_t entries [iw_cfg_pkg::WINDOW_SIZE-1:0],
    input  wire [iw_cfg_pkg::WINDOW_SIZE-1:0] taken_mask,
    input  wire iw_types_pkg::wakeup_t        wakeup,
    input  wire                               branch_hazard,
    input  wire iw_types_pkg::context_t       hazard_context,
    input  wire                               d_done,
    input  wire iw_types_pkg::dec_inst_t      d_inst,
    output iw_types_pkg::window_entry_t       updated [iw_cfg_pkg::WINDOW_SIZE-1:0],
    output iw_types_pkg::window_entry_t       incoming
);

    import iw_cfg_pkg::*;
    import iw_types_pkg::*;

    // grab broadcast data for a waiting operand with a matching tag
    function automatic operand_t capture_operand(input operand_t op, input wakeup_t wu);
        operand_t res;
        res = op;
        if (wu.valid && !op.ready && (op.tag == wu.tag)) begin
            res.ready = 1'b1;
            res.data  = wu.data;
        end
        return res;
    endfunction

    function automatic dec_inst_t capture_inst(input dec_inst_t inst, input wakeup_t wu);
        dec_inst_t res;
        res     = inst;
        res.rs1 = capture_operand(inst.rs1, wu);
        res.rs2 = capture_operand(inst.rs2, wu);
        return res;
    endfunction

    logic [WINDOW_SIZE-1:0] flush_hit;
    logic                   incoming_flush;

    always_comb begin
        for (int k = 0; k < WINDOW_SIZE; k++) begin
            flush_hit[k] = branch_hazard && (|(entries[k].inst.ctx & hazard_context));
        end
        incoming_flush = branch_hazard && (|(d_inst.ctx & hazard_context));
    end

    always_comb begin
        for (int k = 0; k < WINDOW_SIZE; k++) begin
            updated[k].inst = capture_inst(entries[k].inst, wakeup);
            // issued or squashed entries drop out here
            updated[k].valid = entries[k].valid && !taken_mask[k] && !flush_hit[k];
        end
    end

    // decoder instruction sees the same wakeup and flush as stored ones
    always_comb begin
        incoming.inst  = capture_inst(d_inst, wakeup);
        incoming.valid = d_done && !incoming_flush;
    end

endmodule

`default_nettype wire

//--- design/window_compact.sv
`default_nettype none

module window_compact (
    input  wire [iw_cfg_pkg::WINDOW_SIZE-1:0]    keep,
    output iw_types_pkg::slot_id_t               source_slot [iw_cfg_pkg::WINDOW_SIZE-1:0],
    output logic [iw_cfg_pkg::WINDOW_SIZE-1:0]   source_valid,
    output iw_types_pkg::slot_id_t               fill_slot,
    output logic                                 accept_able
);

    import iw_cfg_pkg::*;
    import iw_types_pkg::*;

    // one extra bit so a full window can be counted
    logic [SLOT_ID_WIDTH:0] pos [WINDOW_SIZE-1:0];
    logic [SLOT_ID_WIDTH:0] survivors;

    // survivors below each slot give its new position
    always_comb begin
        survivors = '0;
        for (int i = 0; i < WINDOW_SIZE; i++) begin
            pos[i]    = survivors;
            survivors = survivors + keep[i];
        end
    end

    // invert the mapping, one source per destination at most
    always_comb begin
        for (int d = 0; d < WINDOW_SIZE; d++) begin
            source_valid[d] = 1'b0;
            source_slot[d]  = '0;
            for (int i = 0; i < WINDOW_SIZE; i++) begin
                if (keep[i] && (pos[i] == (SLOT_ID_WIDTH+1)'(d))) begin
                    source_valid[d] = 1'b1;
                    source_slot[d]  = slot_id_t'(i);
                end
            end
        end
    end

    // new instruction lands right behind the survivors
    assign fill_slot   = survivors[SLOT_ID_WIDTH-1:0];
    assign accept_able = (survivors < (SLOT_ID_WIDTH+1)'(WINDOW_SIZE));

endmodule

`default_nettype wire

//--- tests/inst_window_props.sv
`default_nettype none

module inst_window_props (
    input wire                            clk,
    input wire                            reset,
    input wire                            order,
    input wire                            accept_able,
    input wire                            accepted,
    input wire                            branch_hazard,
    input wire iw_types_pkg::wakeup_t     wakeup,
    input wire iw_types_pkg::issue_inst_t issue
);

    import iw_types_pkg::*;

    // entries are cleared by the reset edge, so nothing can be ordered afterwards
    order_low_after_reset: assert property (@(posedge clk) reset |=> !order)
        else $error("order high during or right after reset");

    accept_after_reset: assert property (@(posedge clk) reset |=> accept_able)
        else $error("accept_able low right after reset");

    // held instruction stays put unless a wakeup or flush can reorder the window
    issue_stable: assert property (@(posedge clk) disable iff (reset)
        (order && !accepted && !branch_hazard && !wakeup.valid) |=> $stable(issue))
        else $error("issue changed while held by back-pressure");

endmodule

bind inst_window inst_window_props i_inst_window_props (
    .clk           (clk),
    .reset         (reset),
    .order         (order),
    .accept_able   (accept_able),
    .accepted      (accepted),
    .branch_hazard (branch_hazard),
    .wakeup        (wakeup),
    .issue         (issue)
);

`default_nettype wire

//--- tests/tb_inst_window.sv
`default_nettype none

module tb_inst_window;

    import iw_cfg_pkg::*;
    import iw_types_pkg::*;

    // reset, directed tests with their drains, then the random run
    localparam int TEST_CYCLES = 5 + 160 + 200 + 40;
    localparam wakeup_t NO_WAKE = '0;

    logic        clk;
    logic        reset;
    logic        d_done;
    dec_inst_t   d_inst;
    logic        accept_able;
    wakeup_t     wakeup;
    logic        branch_hazard;
    context_t    hazard_context;
    logic        order;
    issue_inst_t issue;
    logic        accepted;

    // reference model, queue front is the oldest instruction
    dec_inst_t   model_q[$];
    logic        exp_order;
    logic        exp_accept;
    issue_inst_t exp_issue;
    logic        took;
    int          errors;
    int          issued;
    string       test_name;

    inst_window i_inst_window (
        .clk            (clk),
        .reset          (reset),
        .d_done         (d_done),
        .d_inst         (d_inst),
        .accept_able    (accept_able),
        .wakeup         (wakeup),
        .branch_hazard  (branch_hazard),
        .hazard_context (hazard_context),
        .order          (order),
        .issue          (issue),
        .accepted       (accepted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (TEST_CYCLES * 2) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", TEST_CYCLES * 2);
        $display("Test failures found");
        $finish;
    end

    order_check: assert property (@(posedge clk) disable iff (reset) order == exp_order)
        else begin
            errors++;
            $display("** Error [%s] order expected %0b actual %0b",
                     test_name, $sampled(exp_order), $sampled(order));
        end

    issue_check: assert property (@(posedge clk) disable iff (reset)
        order |-> issue == exp_issue)
        else begin
            errors++;
            $display("** Error [%s] issue expected %h actual %h",
                     test_name, $sampled(exp_issue), $sampled(issue));
        end

    accept_check: assert property (@(posedge clk) disable iff (reset)
        accept_able == exp_accept)
        else begin
            errors++;
            $display("** Error [%s] accept_able expected %0b actual %0b",
                     test_name, $sampled(exp_accept), $sampled(accept_able));
        end

    function automatic operand_t wake_operand(input operand_t op, input wakeup_t wu);
        if (wu.valid && !op.ready && (op.tag == wu.tag)) begin
            op.ready = 1'b1;
            op.data  = wu.data;
        end
        return op;
    endfunction

    function automatic dec_inst_t wake_inst(input dec_inst_t inst, input wakeup_t wu);
        inst.rs1 = wake_operand(inst.rs1, wu);
        inst.rs2 = wake_operand(inst.rs2, wu);
        return inst;
    endfunction

    function automatic logic flushed(input context_t ctx);
        return branch_hazard && (|(ctx & hazard_context));
    endfunction

    function automatic int oldest_ready();
        for (int i = 0; i < model_q.size(); i++) begin
            if (model_q[i].rs1.ready && model_q[i].rs2.ready && (model_q[i].exec_type != '0)) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int count_survivors();
        int sel;
        int n;
        sel = oldest_ready();
        n   = 0;
        for (int i = 0; i < model_q.size(); i++) begin
            if (!(i == sel && accepted) && !flushed(model_q[i].ctx)) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic wakeup_t wake(input preg_t tag, input word_t data);
        wakeup_t wu;
        wu.valid = 1'b1;
        wu.tag   = tag;
        wu.data  = data;
        return wu;
    endfunction

    function automatic dec_inst_t make_inst(input context_t ctx, input logic r1_ready,
                                            input preg_t r1_tag, input logic r2_ready,
                                            input preg_t r2_tag);
        dec_inst_t inst;
        inst.exec_type = exec_type_t'(1 << ($urandom % EXEC_TYPE_WIDTH));
        inst.func3     = func3_t'($urandom);
        inst.rs1       = '{ready: r1_ready, tag: r1_tag, data: $urandom};
        inst.rs2       = '{ready: r2_ready, tag: r2_tag, data: $urandom};
        inst.rd        = preg_t'($urandom);
        inst.ctx       = ctx;
        return inst;
    endfunction

    // retire the cycle that just ended into the model
    task automatic advance();
        dec_inst_t next_q[$];
        int sel;
        @(negedge clk);
        sel  = oldest_ready();
        took = d_done && (count_survivors() < WINDOW_SIZE);
        if (sel >= 0 && accepted) begin
            issued++;
        end
        for (int i = 0; i < model_q.size(); i++) begin
            if (!(i == sel && accepted) && !flushed(model_q[i].ctx)) begin
                next_q.push_back(wake_inst(model_q[i], wakeup));
            end
        end
        if (took && !flushed(d_inst.ctx)) begin
            next_q.push_back(wake_inst(d_inst, wakeup));
        end
        model_q = next_q;
    endtask

    task automatic drive(input logic done, input dec_inst_t inst, input wakeup_t wu,
                         input logic hazard, input context_t hazard_ctx, input logic acc);
        int sel;
        d_done         = done;
        d_inst         = inst;
        wakeup         = wu;
        branch_hazard  = hazard;
        hazard_context = hazard_ctx;
        accepted       = acc;
        sel            = oldest_ready();
        exp_order      = (sel >= 0);
        exp_issue      = '0;
        if (sel >= 0) begin
            exp_issue = '{exec_type: model_q[sel].exec_type, func3: model_q[sel].func3,
                          rs1_data: model_q[sel].rs1.data, rs2_data: model_q[sel].rs2.data,
                          rd: model_q[sel].rd, ctx: model_q[sel].ctx};
        end
        exp_accept = (count_survivors() < WINDOW_SIZE);
    endtask

    task automatic next_cycle(input logic done, input dec_inst_t inst, input wakeup_t wu,
                              input logic hazard, input context_t hazard_ctx, input logic acc);
        advance();
        drive(done, inst, wu, hazard, hazard_ctx, acc);
    endtask

    // accept everything and sweep wakeups over tags 0..7 until the window is empty
    task automatic drain();
        int n;
        n = 0;
        do begin
            next_cycle(1'b0, '0, wake(preg_t'(n % 8), $urandom), 1'b0, '0, 1'b1);
            n++;
        end while (model_q.size() != 0);
    endtask

    initial begin
        dec_inst_t inst_a;
        dec_inst_t inst_b;
        wakeup_t   wu;
        void'($urandom(6588));
        errors = 0;
        issued = 0;
        took = 1'b0;
        test_name = "reset";
        reset = 1'b1;
        drive(1'b0, '0, NO_WAKE, 1'b0, '0, 1'b0);
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        drive(1'b0, '0, NO_WAKE, 1'b0, '0, 1'b0);

        test_name = "single_ready";
        next_cycle(1'b1, make_inst(4'b0001, 1'b1, 6'd0, 1'b1, 6'd0), NO_WAKE, 1'b0, '0, 1'b0);
        next_cycle(1'b0, '0, NO_WAKE, 1'b0, '0, 1'b0);
        drain();

        test_name = "oldest_first";
        inst_a = make_inst(4'b0001, 1'b0, 6'd5, 1'b1, 6'd0);
        inst_b = make_inst(4'b0001, 1'b1, 6'd0, 1'b1, 6'd0);
        next_cycle(1'b1, inst_a, NO_WAKE, 1'b0, '0, 1'b1);
        next_cycle(1'b1, inst_b, NO_WAKE, 1'b0, '0, 1'b1);
        next_cycle(1'b0, '0, NO_WAKE, 1'b0, '0, 1'b1);
        next_cycle(1'b0, '0, wake(6'd5, $urandom), 1'b0, '0, 1'b1);
        drain();

        test_name = "back_pressure";
        for (int i = 0; i < WINDOW_SIZE; i++) begin
            next_cycle(1'b1, make_inst(4'b0001, 1'b1, 6'd0, 1'b1, 6'd0), NO_WAKE, 1'b0, '0, 1'b0);
        end
        repeat (3) next_cycle(1'b0, '0, NO_WAKE, 1'b0, '0, 1'b0);
        drain();

        test_name = "flush";
        for (int i = 0; i < 6; i++) begin
            inst_a = make_inst((i % 2) ? 4'b0100 : 4'b0010, 1'b1, 6'd0, 1'b1, 6'd0);
            next_cycle(1'b1, inst_a, NO_WAKE, 1'b0, '0, 1'b0);
        end
        // incoming bit-1 instruction is dropped together with the stored ones
        inst_b = make_inst(4'b0010, 1'b1, 6'd0, 1'b1, 6'd0);
        next_cycle(1'b1, inst_b, NO_WAKE, 1'b1, 4'b0010, 1'b0);
        drain();

        test_name = "random";
        for (int c = 0; c < 200; c++) begin
            advance();
            // a refused instruction is held until taken
            if (!(d_done && !took)) begin
                inst_a = make_inst(context_t'(1 << ($urandom % CONTEXT_WIDTH)),
                                   $urandom % 2, preg_t'($urandom % 8),
                                   $urandom % 2, preg_t'($urandom % 8));
                d_done = ($urandom % 3) != 0;
                d_inst = inst_a;
            end
            wu = ($urandom % 2) ? wake(preg_t'($urandom % 8), $urandom) : NO_WAKE;
            drive(d_done, d_inst, wu, ($urandom % 16) == 0,
                  context_t'(1 << ($urandom % CONTEXT_WIDTH)), ($urandom % 4) != 0);
        end
        drain();
        advance();

        $display("issued %0d instructions, %0d errors", issued, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
